//--- Makefile
TOP := tb_team_04

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing --top-module team_04_wrapper \
		design/cpu_pkg.sv design/cpu_bus_if.sv design/wb_slave_regs.sv \
		design/cpu_core.sv design/wb_master_port.sv design/team_04_wrapper.sv

clean:
	rm -rf obj_dir sim.log

//--- design/cpu_bus_if.sv
// Core to master port request bus
// One-cycle req strobe out, one-cycle done pulse back
`timescale 1ns/10ps

interface cpu_bus_if
    import cpu_pkg::*;
();

    logic            req;   // Request strobe, one cycle
    logic            we;    // Store when high
    logic [XLEN-1:0] adr;   // Byte address
    logic [XLEN-1:0] wdat;  // Store data
    logic [XLEN-1:0] rdat;  // Load data, valid with done
    logic            done;  // Transfer complete, one cycle

    modport core (
        output req, we, adr, wdat,
        input  rdat, done
    );

    modport master (
        input  req, we, adr, wdat,
        output rdat, done
    );

endinterface

//--- design/cpu_core.sv
// Accumulator CPU core
// Fetch, decode and execute FSM, one instruction fetch per step,
// loads and stores go out over the request bus to the master port
`timescale 1ns/10ps

module cpu_core
    import cpu_pkg::*;
(
    input  logic            wb_clk_i,
    input  logic            rst_i,
    input  logic            start_i,
    input  logic [XLEN-1:0] prog_base_i,
    cpu_bus_if.core         bus,
    output logic            busy_o,
    output logic            halted_o,
    output logic [XLEN-1:0] acc_o,
    output logic [XLEN-1:0] gpio_o
);

    logic [CORE_ST_W-1:0]  state_q;
    logic [ADDR_OFS_W-1:0] pc_q;      // Word index into program
    logic [XLEN-1:0]       acc_q;
    cpu_instr_u            ir_q;      // Current instruction
    opcode_e               op;
    logic [XLEN-1:0]       imm_sx;    // Sign-extended immediate
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       fetch_adr;
    logic [XLEN-1:0]       data_adr;
    logic                  mem_op;    // LD or ST in execute

    assign op        = ir_q.imm_fmt.opcode;
    assign imm_sx    = {{SX_W{ir_q.imm_fmt.imm[ADDR_OFS_W-1]}}, ir_q.imm_fmt.imm};
    assign fetch_adr = prog_base_i + {{(SX_W-2){1'b0}}, pc_q, 2'b00};
    assign data_adr  = {{(SX_W-2){1'b0}}, ir_q.mem_fmt.addr, 2'b00};
    assign mem_op    = (op == OP_LD) || (op == OP_ST);

    assign busy_o = (state_q != CORE_IDLE);
    assign acc_o  = acc_q;

    // ALU, accumulator against immediate
    always_comb begin
        case (ir_q.imm_fmt.fn)
            FN_LDI:  alu_res = imm_sx;
            FN_ADD:  alu_res = acc_q + imm_sx;
            FN_SUB:  alu_res = acc_q - imm_sx;
            FN_AND:  alu_res = acc_q & imm_sx;
            FN_OR:   alu_res = acc_q | imm_sx;
            FN_XOR:  alu_res = acc_q ^ imm_sx;
            default: alu_res = acc_q;            // Unknown fn keeps acc
        endcase
    end

    // Request strobes, fetch state or a memory op in execute
    always_comb begin
        bus.req  = 1'b0;
        bus.we   = 1'b0;
        bus.wdat = acc_q;                        // Only used for stores
        bus.adr  = (state_q == CORE_EXEC) ? data_adr : fetch_adr;
        if (state_q == CORE_FETCH) begin
            bus.req = 1'b1;
        end else if ((state_q == CORE_EXEC) && mem_op) begin
            bus.req = 1'b1;
            bus.we  = (op == OP_ST);
        end
    end

    // Main FSM
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state_q  <= CORE_IDLE;
            pc_q     <= '0;
            acc_q    <= '0;
            gpio_o   <= '0;
            halted_o <= 1'b0;
        end else begin
            case (state_q)
                CORE_IDLE: begin
                    if (start_i) begin
                        pc_q     <= '0;
                        halted_o <= 1'b0;
                        state_q  <= CORE_FETCH;
                    end
                end
                CORE_FETCH: state_q <= CORE_FETCH_WAIT; // req goes out here
                CORE_FETCH_WAIT: begin
                    if (bus.done) state_q <= CORE_EXEC;
                end
                CORE_EXEC: begin
                    case (op)
                        OP_ALU: begin
                            acc_q   <= alu_res;
                            pc_q    <= pc_q + 1'b1;
                            state_q <= CORE_FETCH;
                        end
                        OP_LD, OP_ST: state_q <= CORE_MEM_WAIT; // req issued now
                        OP_JNZ: begin
                            pc_q    <= (acc_q != '0) ? ir_q.mem_fmt.addr : pc_q + 1'b1;
                            state_q <= CORE_FETCH;
                        end
                        OP_OUT: begin
                            gpio_o  <= acc_q;
                            pc_q    <= pc_q + 1'b1;
                            state_q <= CORE_FETCH;
                        end
                        default: begin                // HALT and bad opcodes
                            halted_o <= 1'b1;
                            state_q  <= CORE_IDLE;
                        end
                    endcase
                end
                CORE_MEM_WAIT: begin
                    if (bus.done) begin
                        if (op == OP_LD) acc_q <= bus.rdat;
                        pc_q    <= pc_q + 1'b1;
                        state_q <= CORE_FETCH;
                    end
                end
                default: state_q <= CORE_IDLE;
            endcase
        end
    end

    // Instruction register, loaded from the fetch completion
    always_ff @(posedge wb_clk_i) begin
        if ((state_q == CORE_FETCH_WAIT) && bus.done) begin
            ir_q <= bus.rdat;
        end
    end

    // One transfer in flight at a time
    a_single_outstanding : assert property (
        @(posedge wb_clk_i) disable iff (rst_i)
        bus.req |=> (!bus.req throughout bus.done[->1])
    );

endmodule

//--- design/cpu_pkg.sv
// Accumulator CPU shared definitions
// Widths, opcode and ALU encodings, slave register map,
// core FSM state codes and the instruction word layout
package cpu_pkg;

    localparam int XLEN       = 32;   // Data and address width
    localparam int ADDR_OFS_W = 24;   // Immediate / word address field
    localparam int SX_W       = XLEN - ADDR_OFS_W; // Sign extension bits

    // Slave register word offsets, from address bits 3:2
    localparam logic [1:0] REG_CTRL      = 2'd0;
    localparam logic [1:0] REG_PROG_BASE = 2'd1;
    localparam logic [1:0] REG_STATUS    = 2'd2;
    localparam logic [1:0] REG_ACC       = 2'd3;

    // Core FSM states
    localparam int         CORE_ST_W       = 3;
    localparam logic [2:0] CORE_IDLE       = 3'd0; // Waiting for start
    localparam logic [2:0] CORE_FETCH      = 3'd1; // Issue fetch request
    localparam logic [2:0] CORE_FETCH_WAIT = 3'd2; // Wait for instruction
    localparam logic [2:0] CORE_EXEC       = 3'd3; // Decode and execute
    localparam logic [2:0] CORE_MEM_WAIT   = 3'd4; // Wait for load/store

    typedef enum logic [3:0] {
        OP_ALU  = 4'd0,  // Acc op immediate
        OP_LD   = 4'd1,  // Acc from memory
        OP_ST   = 4'd2,  // Acc to memory
        OP_JNZ  = 4'd3,  // Jump if acc nonzero
        OP_OUT  = 4'd4,  // Acc to GPIO
        OP_HALT = 4'd5
    } opcode_e;

    typedef enum logic [3:0] {
        FN_LDI = 4'd0,   // Load immediate
        FN_ADD = 4'd1,
        FN_SUB = 4'd2,
        FN_AND = 4'd3,
        FN_OR  = 4'd4,
        FN_XOR = 4'd5
    } alu_fn_e;

    // One instruction word, two views of the low 28 bits
    typedef union packed {
        struct packed {
            opcode_e                      opcode;
            alu_fn_e                      fn;
            logic signed [ADDR_OFS_W-1:0] imm;  // Sign extended to XLEN
        } imm_fmt;
        struct packed {
            opcode_e                 opcode;
            logic [3:0]              rsvd;      // Unused
            logic [ADDR_OFS_W-1:0]   addr;      // Word address or jump target
        } mem_fmt;
    } cpu_instr_u;

endpackage

//--- design/team_04_wrapper.sv
// Team 04 CPU subsystem top level
// Slave register block, accumulator core and master port
// connected to the chip Wishbone buses and GPIO outputs
`timescale 1ns/10ps

module team_04_wrapper
    import cpu_pkg::*;
(
    input  logic            wb_clk_i,
    input  logic            rst_i,
    // Slave bus from the management core
    input  logic            wbs_stb_i,
    input  logic            wbs_cyc_i,
    input  logic            wbs_we_i,
    input  logic [3:0]      wbs_sel_i,
    input  logic [XLEN-1:0] wbs_dat_i,
    input  logic [XLEN-1:0] wbs_adr_i,
    output logic            wbs_ack_o,
    output logic [XLEN-1:0] wbs_dat_o,
    // Master bus to program/data memory
    output logic [XLEN-1:0] wbm_adr_o,
    output logic [XLEN-1:0] wbm_dat_o,
    output logic [3:0]      wbm_sel_o,
    output logic            wbm_we_o,
    output logic            wbm_stb_o,
    output logic            wbm_cyc_o,
    input  logic [XLEN-1:0] wbm_dat_i,
    input  logic            wbm_ack_i,
    // Accumulator output register
    output logic [XLEN-1:0] gpio_o
);

    logic            start;      // Run pulse to core
    logic [XLEN-1:0] prog_base;
    logic            busy;
    logic            halted;
    logic [XLEN-1:0] acc;

    cpu_bus_if bus_if ();        // Core to master port

    wb_slave_regs wb_slave_regs_inst (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_adr_i   (wbs_adr_i),
        .busy_i      (busy),
        .halted_i    (halted),
        .acc_i       (acc),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .start_o     (start),
        .prog_base_o (prog_base)
    );

    cpu_core cpu_core_inst (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .start_i     (start),
        .prog_base_i (prog_base),
        .bus         (bus_if.core),
        .busy_o      (busy),
        .halted_o    (halted),
        .acc_o       (acc),
        .gpio_o      (gpio_o)
    );

    wb_master_port wb_master_port_inst (
        .wb_clk_i  (wb_clk_i),
        .rst_i     (rst_i),
        .wbm_dat_i (wbm_dat_i),
        .wbm_ack_i (wbm_ack_i),
        .bus       (bus_if.master),
        .wbm_adr_o (wbm_adr_o),
        .wbm_dat_o (wbm_dat_o),
        .wbm_sel_o (wbm_sel_o),
        .wbm_we_o  (wbm_we_o),
        .wbm_stb_o (wbm_stb_o),
        .wbm_cyc_o (wbm_cyc_o)
    );

endmodule

//--- design/wb_master_port.sv
// Wishbone master port
// Turns a core request pulse into a classic bus cycle held until ack,
// then returns read data with a done pulse
`timescale 1ns/10ps

module wb_master_port
    import cpu_pkg::*;
(
    input  logic            wb_clk_i,
    input  logic            rst_i,
    input  logic [XLEN-1:0] wbm_dat_i,
    input  logic            wbm_ack_i,
    cpu_bus_if.master       bus,
    output logic [XLEN-1:0] wbm_adr_o,
    output logic [XLEN-1:0] wbm_dat_o,
    output logic [3:0]      wbm_sel_o,
    output logic            wbm_we_o,
    output logic            wbm_stb_o,
    output logic            wbm_cyc_o
);

    logic accept;  // Request taken this cycle
    logic finish;  // Slave acked this cycle

    assign accept    = bus.req && !wbm_cyc_o;
    assign finish    = wbm_cyc_o && wbm_ack_i;
    assign wbm_sel_o = 4'hf;                     // Word transfers only

    // Cycle control
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wbm_cyc_o <= 1'b0;
            wbm_stb_o <= 1'b0;
            wbm_we_o  <= 1'b0;
            bus.done  <= 1'b0;
        end else begin
            bus.done <= finish;                  // Cycle after ack
            if (accept) begin
                wbm_cyc_o <= 1'b1;
                wbm_stb_o <= 1'b1;
                wbm_we_o  <= bus.we;
            end else if (finish) begin
                wbm_cyc_o <= 1'b0;
                wbm_stb_o <= 1'b0;
                wbm_we_o  <= 1'b0;
            end
        end
    end

    // Address and write data, held for the whole cycle
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            wbm_adr_o <= bus.adr;
            wbm_dat_o <= bus.wdat;
        end
    end

    // Read data capture, valid with done
    always_ff @(posedge wb_clk_i) begin
        if (finish) bus.rdat <= wbm_dat_i;
    end

    a_stb_in_cyc : assert property (
        @(posedge wb_clk_i) disable iff (rst_i)
        wbm_stb_o |-> wbm_cyc_o
    );

    // Slave may stall, request fields must not move
    a_hold_stable : assert property (
        @(posedge wb_clk_i) disable iff (rst_i)
        (wbm_stb_o && !wbm_ack_i) |=> ($stable(wbm_adr_o) && $stable(wbm_we_o)
                                       && $stable(wbm_dat_o))
    );

endmodule

//--- design/wb_slave_regs.sv
// Wishbone slave register block
// Holds program base and start control for the CPU core,
// returns core status and accumulator on reads
`timescale 1ns/10ps

module wb_slave_regs
    import cpu_pkg::*;
(
    input  logic            wb_clk_i,
    input  logic            rst_i,
    input  logic            wbs_stb_i,
    input  logic            wbs_cyc_i,
    input  logic            wbs_we_i,
    input  logic [3:0]      wbs_sel_i,
    input  logic [XLEN-1:0] wbs_dat_i,
    input  logic [XLEN-1:0] wbs_adr_i,
    input  logic            busy_i,
    input  logic            halted_i,
    input  logic [XLEN-1:0] acc_i,
    output logic            wbs_ack_o,
    output logic [XLEN-1:0] wbs_dat_o,
    output logic            start_o,
    output logic [XLEN-1:0] prog_base_o
);

    logic       req;      // New request this cycle
    logic       wr_req;
    logic [1:0] reg_sel;  // Word offset
    logic [XLEN-1:0] rd_mux;

    // No second request accepted during the ack cycle
    assign req     = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
    assign wr_req  = req & wbs_we_i;
    assign reg_sel = wbs_adr_i[3:2];

    // Read data select
    always_comb begin
        case (reg_sel)
            REG_CTRL:      rd_mux = '0;          // Start is write-only
            REG_PROG_BASE: rd_mux = prog_base_o;
            REG_STATUS:    rd_mux = {{(XLEN-2){1'b0}}, halted_i, busy_i};
            default:       rd_mux = acc_i;       // REG_ACC
        endcase
    end

    // Ack and start pulse
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wbs_ack_o <= 1'b0;
            start_o   <= 1'b0;
        end else begin
            wbs_ack_o <= req;                    // Always one cycle later
            // Start only from an idle core, byte 0 must be selected
            start_o   <= wr_req && (reg_sel == REG_CTRL) && wbs_sel_i[0]
                         && wbs_dat_i[0] && !busy_i;
        end
    end

    // Program base, byte lanes under sel
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            prog_base_o <= '0;
        end else if (wr_req && (reg_sel == REG_PROG_BASE)) begin
            for (int b = 0; b < 4; b++) begin
                if (wbs_sel_i[b]) begin
                    prog_base_o[8*b +: 8] <= wbs_dat_i[8*b +: 8];
                end
            end
        end
    end

    // Read data lands in the ack cycle
    always_ff @(posedge wb_clk_i) begin
        if (req && !wbs_we_i) begin
            wbs_dat_o <= rd_mux;
        end
    end

    // Master must hold cyc until it sees our ack
    a_ack_in_cycle : assert property (
        @(posedge wb_clk_i) disable iff (rst_i)
        wbs_ack_o |-> wbs_cyc_i
    );

endmodule

//--- sim/tb_team_04.sv
// Testbench for the team 04 CPU subsystem
// Directed tests through the slave registers, programs run out of
// a Wishbone memory model with optional random wait states
`timescale 1ns/10ps

module tb_team_04
    import cpu_pkg::*;
();

    logic            wb_clk_i = 1'b0;
    logic            rst_i;
    logic            wbs_stb_i, wbs_cyc_i, wbs_we_i, wbs_ack_o;
    logic [3:0]      wbs_sel_i, wbm_sel_o;
    logic [XLEN-1:0] wbs_dat_i, wbs_adr_i, wbs_dat_o;
    logic [XLEN-1:0] wbm_adr_o, wbm_dat_o, wbm_dat_i, gpio_o;
    logic            wbm_we_o, wbm_stb_o, wbm_cyc_o, wbm_ack_i;
    logic            stall_en, bd_we;    // Memory model controls
    logic [7:0]      bd_idx;
    logic [XLEN-1:0] bd_dat;
    int              errors = 0;
    int              checks = 0;
    cpu_instr_u      prog[$];            // Program being built

    always #2 wb_clk_i = ~wb_clk_i;     // 4 ns period

    team_04_wrapper team_04_wrapper_inst (.*);

    wb_mem_model mem_inst (
        .clk_i (wb_clk_i), .rst_i (rst_i), .cyc_i (wbm_cyc_o), .stb_i (wbm_stb_o),
        .we_i (wbm_we_o), .adr_i (wbm_adr_o), .dat_i (wbm_dat_o), .stall_en_i (stall_en),
        .bd_we_i (bd_we), .bd_idx_i (bd_idx), .bd_dat_i (bd_dat),
        .ack_o (wbm_ack_i), .dat_o (wbm_dat_i)
    );

    task automatic check_word(input string name, input logic [XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input logic [3:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Every master cycle is a full word transfer
    always @(negedge wb_clk_i) begin
        if (wbm_cyc_o && wbm_stb_o) check_sel("wbm_sel_o", wbm_sel_o, 4'hf);
    end

    function automatic logic [XLEN-1:0] sext(input logic [ADDR_OFS_W-1:0] v);
        return {{SX_W{v[ADDR_OFS_W-1]}}, v};
    endfunction

    function automatic cpu_instr_u alu_instr(input alu_fn_e fn, input logic [23:0] imm);
        cpu_instr_u w;
        w.imm_fmt = '{OP_ALU, fn, imm};
        return w;
    endfunction

    function automatic cpu_instr_u addr_instr(input opcode_e op, input logic [23:0] a);
        cpu_instr_u w;
        w.mem_fmt = '{op, 4'h0, a};
        return w;
    endfunction

    // Slave accesses start and end on a falling edge
    task automatic wb_write(input logic [1:0] ofs, input logic [XLEN-1:0] dat,
                            input logic [3:0] sel);
        int n;
        {wbs_cyc_i, wbs_stb_i, wbs_we_i} = 3'b111;
        wbs_adr_i = {28'h300_0000, ofs, 2'b00};  // Slave window base
        wbs_dat_i = dat;
        wbs_sel_i = sel;
        n = 0;
        do begin
            @(negedge wb_clk_i);
            n++;
        end while (!wbs_ack_o && n < 8);
        if (!wbs_ack_o) begin
            errors++;
            $display("no ack from the slave on a write to offset %0d", ofs);
        end
        @(negedge wb_clk_i);             // Cycle held past the ack edge
        {wbs_cyc_i, wbs_stb_i, wbs_we_i} = 3'b000;
    endtask

    task automatic wb_read(input logic [1:0] ofs, output logic [XLEN-1:0] dat);
        int n;
        {wbs_cyc_i, wbs_stb_i, wbs_we_i} = 3'b110;
        wbs_adr_i = {28'h300_0000, ofs, 2'b00};
        wbs_sel_i = 4'hf;
        n = 0;
        do begin
            @(negedge wb_clk_i);
            n++;
        end while (!wbs_ack_o && n < 8);
        if (!wbs_ack_o) begin
            errors++;
            $display("no ack from the slave on a read of offset %0d", ofs);
        end
        dat = wbs_dat_o;
        @(negedge wb_clk_i);             // Cycle held past the ack edge
        {wbs_cyc_i, wbs_stb_i} = 2'b00;
    endtask

    task automatic poke(input int idx, input logic [XLEN-1:0] dat);
        bd_we  = 1'b1;                   // Lands on the next rising edge
        bd_idx = idx[7:0];
        bd_dat = dat;
        @(negedge wb_clk_i);
        bd_we  = 1'b0;
    endtask

    task automatic load_prog(input int base_word);
        foreach (prog[i]) poke(base_word + i, prog[i]);
        prog.delete();
    endtask

    task automatic wait_halted();
        logic [XLEN-1:0] st;
        int n;
        n = 0;
        do begin
            wb_read(REG_STATUS, st);
            n++;
        end while (!st[1] && n < 500);
        if (!st[1]) begin
            errors++;
            $display("core did not halt within %0d status polls", n);
        end
    endtask

    task automatic run_prog(input logic [XLEN-1:0] base);
        wb_write(REG_PROG_BASE, base, 4'hf);
        wb_write(REG_CTRL, 32'h1, 4'hf);
        wait_halted();
    endtask

    task automatic end_test(input int num, input string name, input int e0);
        $display("test %0d %s: %s", num, name, (errors == e0) ? "ok" : "FAILED");
    endtask

    task automatic apply_reset();
        rst_i = 1'b1;
        repeat (2) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        rst_i = 1'b0;
    endtask

    task automatic reset_and_regs();
        logic [XLEN-1:0] rd;
        int e0;
        e0 = errors;
        wb_read(REG_STATUS, rd);
        check_status("status", rd[1:0], 2'b00);
        check_word("gpio_o", gpio_o, '0);
        wb_write(REG_PROG_BASE, 32'h11223344, 4'hf);
        wb_write(REG_PROG_BASE, 32'haabbccdd, 4'b0101);
        wb_read(REG_PROG_BASE, rd);
        check_word("prog_base", rd, {8'h11, 8'hbb, 8'h33, 8'hdd}); // Lanes 0 and 2 new
        end_test(1, "reset and registers", e0);
    endtask

    task automatic alu_program();
        alu_fn_e         fns [6] = '{FN_LDI, FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR};
        logic [23:0]     imms [6] = '{24'hfffffb, 24'h123456, 24'hffff00,
                                      24'h7ff0f0, 24'h800000, 24'h00abcd};
        logic [XLEN-1:0] acc;
        logic [XLEN-1:0] rd;
        int e0;
        e0  = errors;
        acc = '0;
        foreach (fns[i]) begin
            prog.push_back(alu_instr(fns[i], imms[i]));
            case (fns[i])                // Accumulator model
                FN_LDI:  acc = sext(imms[i]);
                FN_ADD:  acc = acc + sext(imms[i]);
                FN_SUB:  acc = acc - sext(imms[i]);
                FN_AND:  acc = acc & sext(imms[i]);
                FN_OR:   acc = acc | sext(imms[i]);
                default: acc = acc ^ sext(imms[i]);
            endcase
        end
        prog.push_back(addr_instr(OP_HALT, '0));
        load_prog(0);
        run_prog(32'h0);
        wb_read(REG_ACC, rd);
        check_word("acc", rd, acc);
        wb_read(REG_STATUS, rd);
        check_status("status", rd[1:0], 2'b10);
        end_test(2, "alu program", e0);
    endtask

    task automatic load_store();
        logic [XLEN-1:0] ld_val;
        logic [XLEN-1:0] rd;
        int e0;
        e0     = errors;
        ld_val = mem_inst.mem[8'h80];
        prog.push_back(addr_instr(OP_LD, 24'h80));
        prog.push_back(alu_instr(FN_ADD, 24'h000321));
        prog.push_back(addr_instr(OP_ST, 24'h81));
        prog.push_back(addr_instr(OP_HALT, '0));
        load_prog(0);
        run_prog(32'h0);
        check_word("mem[0x81]", mem_inst.mem[8'h81], ld_val + sext(24'h000321));
        wb_read(REG_ACC, rd);
        check_word("acc", rd, ld_val + sext(24'h000321));
        end_test(3, "load and store", e0);
    endtask

    // Exit acc parked at word 0x90, then the final LDI value
    task automatic check_countdown();
        logic [XLEN-1:0] rd;
        check_word("acc at loop exit", mem_inst.mem[8'h90], '0);
        check_word("gpio_o", gpio_o, sext(24'ha5a5a5));
        wb_read(REG_ACC, rd);
        check_word("acc", rd, sext(24'ha5a5a5));
    endtask

    task automatic loop_gpio();
        int e0;
        e0 = errors;
        prog.push_back(alu_instr(FN_LDI, 24'd5));
        prog.push_back(alu_instr(FN_SUB, 24'd1));  // Loop top, word 1
        prog.push_back(addr_instr(OP_OUT, '0));
        prog.push_back(addr_instr(OP_JNZ, 24'd1));
        prog.push_back(addr_instr(OP_ST, 24'h90));
        prog.push_back(alu_instr(FN_LDI, 24'ha5a5a5));
        prog.push_back(addr_instr(OP_OUT, '0));
        prog.push_back(addr_instr(OP_HALT, '0));
        load_prog(16);                   // Byte address 0x40
        poke('h90, '1);
        run_prog(32'h40);
        check_countdown();
        end_test(4, "loop and gpio", e0);
    endtask

    task automatic restart_stalls();
        logic [XLEN-1:0] rd;
        int e0;
        e0 = errors;
        apply_reset();                   // Clears gpio_o, memory keeps its words
        check_word("gpio_o after reset", gpio_o, '0);
        for (int i = 0; i < 8; i++)
            poke(64 + i, mem_inst.mem[8'(16 + i)]);
        poke('h90, '1);
        stall_en = 1'b1;
        wb_write(REG_PROG_BASE, 32'h100, 4'hf);
        wb_write(REG_CTRL, 32'h1, 4'hf);
        wb_read(REG_STATUS, rd);
        check_status("status while running", rd[1:0], 2'b01);
        wb_write(REG_CTRL, 32'h1, 4'hf); // Busy, so no restart
        wait_halted();
        check_countdown();
        stall_en = 1'b0;
        end_test(5, "restart and stalls", e0);
    endtask

    initial begin
        {wbs_cyc_i, wbs_stb_i, wbs_we_i} = 3'b000;
        wbs_sel_i = '0;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        {stall_en, bd_we} = 2'b00;
        bd_idx = '0;
        bd_dat = '0;
        apply_reset();
        reset_and_regs();
        alu_program();
        load_store();
        loop_gpio();
        restart_stalls();
        $display("tests: 5  checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Whole-run watchdog
    initial begin
        #200us;
        $display("run timed out before the tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

//--- sim/wb_mem_model.sv
// Wishbone memory model for the testbench
// 256 words with a backdoor load port, answers each cycle after
// 0 to 3 wait states picked from a Galois LFSR when stalls are on
`timescale 1ns/10ps

module wb_mem_model (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    input  logic        stall_en_i,  // Random wait states when high
    input  logic        bd_we_i,     // Backdoor word write
    input  logic [7:0]  bd_idx_i,
    input  logic [31:0] bd_dat_i,
    output logic        ack_o,
    output logic [31:0] dat_o
);

    logic [31:0] mem [0:255];
    logic [31:0] lfsr_q;
    logic        active_q;           // Request seen, counting waits
    logic [1:0]  wait_q;
    logic [7:0]  idx;

    assign idx = adr_i[9:2];         // Word index

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Fill pattern mixes every address bit
    initial begin
        for (int i = 0; i < 256; i++) mem[8'(i)] <= (i * 32'h9e3779b1) ^ 32'h5a5a5a5a;
    end

    task automatic answer();
        ack_o <= 1'b1;
        if (we_i) mem[idx] <= dat_i;
        else      dat_o    <= mem[idx];  // Valid in the ack cycle
    endtask

    always @(posedge clk_i) begin : bus_side
        logic [31:0] s;
        logic [1:0]  waits;
        ack_o <= 1'b0;
        if (rst_i) begin
            active_q <= 1'b0;
            wait_q   <= '0;
            lfsr_q   <= 32'hdadb866d;
        end else begin
            if (bd_we_i) mem[bd_idx_i] <= bd_dat_i;
            if (cyc_i && stb_i && !ack_o) begin
                if (!active_q) begin
                    waits = 2'd0;
                    if (stall_en_i) begin  // One LFSR step per bit taken
                        s        = lfsr_q;
                        waits[0] = s[0];
                        s        = lfsr_next(s);
                        waits[1] = s[0];
                        lfsr_q  <= lfsr_next(s);
                    end
                    if (waits == 2'd0) begin
                        answer();
                    end else begin
                        active_q <= 1'b1;
                        wait_q   <= waits - 2'd1;
                    end
                end else if (wait_q == 2'd0) begin
                    answer();
                    active_q <= 1'b0;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

//--- tb.f
design/cpu_pkg.sv
design/cpu_bus_if.sv
design/wb_slave_regs.sv
design/cpu_core.sv
design/wb_master_port.sv
design/team_04_wrapper.sv
sim/wb_mem_model.sv
sim/tb_team_04.sv
